/* project.f */
verilog/wiscPkg.sv
verilog/alu.sv
verilog/instrDecoder.sv
verilog/regFile.sv
verilog/pcCounter.sv
verilog/coreControl.sv
verilog/instrMem.sv
verilog/wiscCore.sv
dv/wiscCore_checker.sv
dv/wiscCoreTb.sv

/* Bender.yml */
package:
  name: wisc_core

sources:
  - files:
      - verilog/wiscPkg.sv
      - verilog/alu.sv
      - verilog/instrDecoder.sv
      - verilog/regFile.sv
      - verilog/pcCounter.sv
      - verilog/coreControl.sv
      - verilog/instrMem.sv
      - verilog/wiscCore.sv
  - target: test
    files:
      - dv/wiscCore_checker.sv
      - dv/wiscCoreTb.sv

/* dv/wiscCoreTb.sv */
module wiscCoreTb;
    import wiscPkg::*;

    localparam int clkPeriod  = 8;
    localparam int runCount   = 7;    // Program runs, the rerun included
    localparam int maxProgLen = 64;
    localparam int runCycles  = 5 * maxProgLen + 16;   // Load plus four cycles each, with slack

    logic                    clk;
    logic                    arstN;
    logic                    start;
    logic                    progWe;
    logic [pcWidth-1:0]      progAddr;
    logic [dataWidth-1:0]    progData;
    logic                    halted;
    logic                    retireValid;
    logic [regAddrWidth-1:0] retireReg;
    logic [dataWidth-1:0]    retireData;

    logic [dataWidth-1:0]    prog[$];
    logic [dataWidth-1:0]    shadow[numRegs];   // Mirrors the register file
    logic [regAddrWidth-1:0] expReg[$];
    logic [dataWidth-1:0]    expData[$];
    int                      expCycle[$];
    int                      haltCycle;
    string                   testName;

    wiscCore u_dut (.clk(clk), .arstN(arstN), .start(start), .progWe(progWe),
        .progAddr(progAddr), .progData(progData), .halted(halted),
        .retireValid(retireValid), .retireReg(retireReg), .retireData(retireData));

    always #(clkPeriod / 2) clk = ~clk;

    task automatic reportFailure(input string what);
        $display("%s", what);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic checkValue(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            reportFailure($sformatf("** Error [%s] %s: expected 0x%0h, actual 0x%0h",
                testName, what, expected, actual));
        end
    endtask

    function automatic logic [dataWidth-1:0] regInstr(opcodeE op, int rs, int rt, int rd,
                                                      int func);
        return {op, 3'(rs), 3'(rt), 3'(rd), 2'(func)};
    endfunction

    function automatic logic [dataWidth-1:0] immInstr(opcodeE op, int rs, int rd, int imm);
        return {op, 3'(rs), 3'(rd), 5'(imm)};
    endfunction

    function automatic logic [dataWidth-1:0] byteInstr(opcodeE op, int rs, int imm);
        return {op, 3'(rs), 8'(imm)};
    endfunction

    // LBI gives the high byte, SLBI shifts it up and adds the low byte
    task automatic loadReg(input int r, input int value);
        prog.push_back(byteInstr(OpLbi, r, value >> 8));
        prog.push_back(byteInstr(OpSlbi, r, value));
    endtask

    // Cases in func order add, B minus A, xor, and-not
    function automatic logic [dataWidth-1:0] arithRef(logic [1:0] sel, logic [dataWidth-1:0] x,
                                                      logic [dataWidth-1:0] y);
        case (sel)
            2'd0:    return x + y;
            2'd1:    return y - x;
            2'd2:    return x ^ y;
            default: return x & ~y;
        endcase
    endfunction

    function automatic logic [dataWidth-1:0] shiftRef(logic [1:0] sel, logic [dataWidth-1:0] x,
                                                      logic [3:0] n);
        case (sel)
            2'd0:    return (x << n) | (x >> (dataWidth - n));
            2'd1:    return x << n;
            2'd2:    return (x >> n) | (x << (dataWidth - n));
            default: return x >> n;
        endcase
    endfunction

    task automatic modelStep(input logic [dataWidth-1:0] ins, output bit writes,
                             output logic [regAddrWidth-1:0] rd, output logic [dataWidth-1:0] val);
        opcodeE               op;
        logic [dataWidth-1:0] rsVal;
        logic [dataWidth-1:0] rtVal;
        logic [dataWidth-1:0] immVal;
        logic [dataWidth-1:0] diff;
        logic [dataWidth:0]   wide;
        op     = opcodeE'(ins[15:11]);
        rsVal  = shadow[ins[10:8]];
        rtVal  = shadow[ins[7:5]];
        diff   = rsVal - rtVal;
        wide   = {1'b0, rsVal} + {1'b0, rtVal};   // Carry lands in the top bit
        immVal = ins[12] ? {11'b0, ins[4:0]} : {{11{ins[4]}}, ins[4:0]};
        writes = 1'b1;
        rd     = ins[4:2];
        val    = '0;
        case (op)
            OpAluArith: val = arithRef(ins[1:0], rsVal, rtVal);
            OpAluShift: val = shiftRef(ins[1:0], rsVal, rtVal[3:0]);
            OpAddi, OpSubi, OpXori, OpAndni: begin
                rd  = ins[7:5];
                val = arithRef(ins[12:11], rsVal, immVal);
            end
            OpRoli, OpSlli, OpRori, OpSrli: begin
                rd  = ins[7:5];
                val = shiftRef(ins[12:11], rsVal, ins[3:0]);
            end
            OpLbi: begin
                rd  = ins[10:8];
                val = {{8{ins[7]}}, ins[7:0]};
            end
            OpSlbi: begin
                rd  = ins[10:8];
                val = {rsVal[7:0], ins[7:0]};
            end
            OpBtr: begin
                for (int i = 0; i < dataWidth; i++) begin
                    val[i] = rsVal[dataWidth-1-i];
                end
            end
            OpSeq: val[0] = (diff == '0);
            OpSlt: val[0] = diff[dataWidth-1];
            OpSle: val[0] = diff[dataWidth-1] || (diff == '0);
            OpSco: val[0] = wide[dataWidth];
            default: writes = 1'b0;   // NOP writes nothing
        endcase
        if (writes) begin
            shadow[rd] = val;
        end
    endtask

    task automatic predictRun();
        bit                      writes;
        logic [regAddrWidth-1:0] rd;
        logic [dataWidth-1:0]    val;
        expReg.delete();
        expData.delete();
        expCycle.delete();
        haltCycle = -1;
        for (int k = 0; k < prog.size() && haltCycle < 0; k++) begin
            if (prog[k][15:11] == OpHalt) begin
                haltCycle = 4 * k + 3;   // FETCH, DECODE, then HALTED
            end else begin
                modelStep(prog[k], writes, rd, val);
                if (writes) begin
                    expReg.push_back(rd);
                    expData.push_back(val);
                    expCycle.push_back(4 * k + 4);   // WRITEBACK of instruction k
                end
            end
        end
    endtask

    task automatic loadProgram();
        prog.push_back(regInstr(OpHalt, 0, 0, 0, 0));
        assert (prog.size() <= maxProgLen) else
            reportFailure("Program is longer than the watchdog budget allows");
        foreach (prog[i]) begin
            @(posedge clk);
            progWe   <= 1'b1;
            progAddr <= 8'(i);
            progData <= prog[i];
        end
        @(posedge clk);
        progWe <= 1'b0;
    endtask

    task automatic runAndCheck();
        int cycle;
        predictRun();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);   // Start edge
        start <= 1'b0;
        cycle = 0;
        do begin
            @(negedge clk);
            cycle++;
            if (retireValid) begin
                assert (expReg.size() > 0) else
                    reportFailure($sformatf("Test %s retired more results than expected",
                        testName));
                checkValue("retire cycle", expCycle.pop_front(), cycle);
                checkValue("retire register", 32'(expReg.pop_front()), 32'(retireReg));
                checkValue("retire data", 32'(expData.pop_front()), 32'(retireData));
            end
        end while (!halted);
        checkValue("halt cycle", haltCycle, cycle);
        assert (expReg.size() == 0) else
            reportFailure($sformatf("Test %s halted before all results retired", testName));
    endtask

    task automatic arithTest();
        testName = "arith";
        prog.delete();
        for (int r = 0; r < 4; r++) begin
            loadReg(r, $urandom());
        end
        prog.push_back(regInstr(OpAluArith, 0, 1, 4, 0));
        prog.push_back(regInstr(OpAluArith, 0, 1, 5, 1));
        prog.push_back(immInstr(OpAddi, 2, 6, $urandom()));
        prog.push_back(immInstr(OpSubi, 3, 7, 5'h10));   // Most negative immediate
        prog.push_back(immInstr(OpAddi, 4, 4, 5'h1f));
        prog.push_back(immInstr(OpSubi, 5, 5, 5'h0f));
        loadProgram();
        runAndCheck();
    endtask

    task automatic logicTest();
        testName = "logic";
        prog.delete();
        for (int r = 0; r < 4; r++) begin
            loadReg(r, $urandom());
        end
        prog.push_back(regInstr(OpAluArith, 0, 1, 4, 2));
        prog.push_back(regInstr(OpAluArith, 2, 3, 5, 3));
        prog.push_back(immInstr(OpXori, 1, 6, 5'h1f));   // High bit must not extend
        prog.push_back(immInstr(OpAndni, 3, 7, 5'h15));
        prog.push_back(immInstr(OpAndni, 0, 0, $urandom()));
        loadProgram();
        runAndCheck();
    endtask

    task automatic shiftTest();
        opcodeE shiftImm[4];
        testName = "shift";
        shiftImm = '{OpRoli, OpSlli, OpRori, OpSrli};
        prog.delete();
        for (int i = 0; i < 4; i++) begin
            loadReg(0, $urandom());
            loadReg(1, (i == 0) ? 0 : (i == 3) ? 15 : $urandom_range(15));
            for (int f = 0; f < 4; f++) begin
                prog.push_back(regInstr(OpAluShift, 0, 1, 2 + f, f));
            end
            for (int f = 0; f < 4; f++) begin
                prog.push_back(immInstr(shiftImm[f], 0, 6, (i * 5 + f) % 16));
            end
        end
        loadProgram();
        runAndCheck();
    endtask

    task automatic compareTest();
        logic [dataWidth-1:0] lhs[5];
        logic [dataWidth-1:0] rhs[5];
        testName = "compare";
        lhs[0] = $urandom();
        rhs[0] = lhs[0];            // Equal operands
        lhs[1] = 16'h8000;
        rhs[1] = 16'h0001;          // Difference overflows
        lhs[2] = 16'h7fff;
        rhs[2] = 16'hffff;
        lhs[3] = 16'hffff;
        rhs[3] = 16'h0001;          // Sum carries out
        lhs[4] = $urandom();
        rhs[4] = $urandom();
        prog.delete();
        for (int p = 0; p < 5; p++) begin
            loadReg(0, lhs[p]);
            loadReg(1, rhs[p]);
            prog.push_back(regInstr(OpSeq, 0, 1, 2, 0));
            prog.push_back(regInstr(OpSlt, 0, 1, 3, 0));
            prog.push_back(regInstr(OpSle, 0, 1, 4, 0));
            prog.push_back(regInstr(OpSco, 0, 1, 5, 0));
        end
        loadProgram();
        runAndCheck();
    endtask

    task automatic constantTest();
        testName = "constant";
        prog.delete();
        for (int r = 0; r < 4; r++) begin
            prog.push_back(byteInstr(OpLbi, r, $urandom()));
            prog.push_back(byteInstr(OpSlbi, r, $urandom()));
            prog.push_back(regInstr(OpBtr, r, 0, r + 4, 0));
        end
        prog.push_back(byteInstr(OpLbi, 1, 8'h80));   // Sign fills the upper byte
        prog.push_back(regInstr(OpBtr, 1, 0, 2, 0));
        loadProgram();
        runAndCheck();
    endtask

    task automatic sequencingTest();
        testName = "sequencing";
        prog.delete();
        loadReg(0, $urandom());
        loadReg(1, $urandom());
        prog.push_back(regInstr(OpNop, 0, 0, 0, 0));
        prog.push_back(regInstr(OpAluArith, 0, 1, 2, 0));
        prog.push_back(regInstr(OpNop, 0, 0, 0, 0));
        prog.push_back(regInstr(OpNop, 0, 0, 0, 0));
        prog.push_back(regInstr(OpAluArith, 2, 1, 3, 2));
        prog.push_back(immInstr(OpAddi, 3, 3, 1));
        prog.push_back(regInstr(OpNop, 0, 0, 0, 0));
        loadProgram();
        runAndCheck();
        testName = "rerun";
        runAndCheck();   // Same program, no reload
    endtask

    initial begin
        clk      = 1'b0;
        arstN    = 1'b0;
        start    = 1'b0;
        progWe   = 1'b0;
        progAddr = '0;
        progData = '0;
        testName = "reset";
        void'($urandom(65));
        foreach (shadow[i]) begin
            shadow[i] = '0;
        end
        repeat (2) @(posedge clk);
        arstN <= 1'b1;
        arithTest();
        logicTest();
        shiftTest();
        compareTest();
        constantTest();
        sequencingTest();
        $display("SIMULATION PASSED");
        $finish;
    end

    // Concurrent checks on the control strobes live in the bound checker
    initial begin
        wait (u_dut.u_checker.failCount != 0);
        reportFailure("A control strobe assertion failed in the bound checker");
    end

    initial begin
        #(runCount * runCycles * clkPeriod);
        reportFailure("Watchdog expired before the tests finished");
    end

endmodule

/* dv/wiscCore_checker.sv */
module wiscCoreChecker (
    input logic clk,
    input logic arstN,
    input logic start,
    input logic halted,
    input logic retireValid
);

    int failCount = 0;   // Watched by the testbench

    // At most one retire per instruction, and instructions take four cycles
    retireSpacing: assert property (@(posedge clk) disable iff (!arstN)
        retireValid |=> !retireValid)
        else begin
            failCount++;
            $error("retireValid was high in two consecutive cycles");
        end

    noRetireHalted: assert property (@(posedge clk) disable iff (!arstN)
        !(retireValid && halted))
        else begin
            failCount++;
            $error("retireValid and halted were high together");
        end

    haltedHolds: assert property (@(posedge clk) disable iff (!arstN)
        halted && !start |=> halted)   // Only start leaves HALTED
        else begin
            failCount++;
            $error("halted dropped without a start pulse");
        end

endmodule

bind wiscCore wiscCoreChecker u_checker (
    .clk(clk),
    .arstN(arstN),
    .start(start),
    .halted(halted),
    .retireValid(retireValid)
);

/* verilog/wiscCore.sv */
module wiscCore (
    input  logic                             clk,
    input  logic                             arstN,
    input  logic                             start,
    input  logic                             progWe,
    input  logic [wiscPkg::pcWidth-1:0]      progAddr,
    input  logic [wiscPkg::dataWidth-1:0]    progData,
    output logic                             halted,
    output logic                             retireValid,
    output logic [wiscPkg::regAddrWidth-1:0] retireReg,
    output logic [wiscPkg::dataWidth-1:0]    retireData
);
    import wiscPkg::*;

    logic [pcWidth-1:0]      pc;
    logic [dataWidth-1:0]    instr;
    logic [regAddrWidth-1:0] rsAddr;
    logic [regAddrWidth-1:0] rtAddr;
    logic [regAddrWidth-1:0] wrAddr;
    aluOpE                   aluOp;
    logic                    invA;
    logic                    invB;
    logic                    cin;
    logic                    useImm;
    logic [dataWidth-1:0]    imm;
    logic                    wrEn;
    logic                    isHalt;
    logic [dataWidth-1:0]    rsData;
    logic [dataWidth-1:0]    rtData;
    logic [dataWidth-1:0]    bOperand;
    logic [dataWidth-1:0]    aluResult;
    logic [dataWidth-1:0]    resultQ;
    logic                    pcClear;
    logic                    pcAdvance;
    logic                    fetchEn;
    logic                    execEn;
    logic                    commit;
    logic                    regWe;

    coreControl u_control (.clk(clk), .arstN(arstN), .start(start), .isHalt(isHalt),
        .pcClear(pcClear), .pcAdvance(pcAdvance), .fetchEn(fetchEn), .execEn(execEn),
        .commit(commit), .halted(halted));

    pcCounter u_pc (.clk(clk), .arstN(arstN), .pcClear(pcClear), .pcAdvance(pcAdvance),
        .pc(pc));

    instrMem u_imem (.clk(clk), .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .pc(pc), .fetchEn(fetchEn), .instr(instr));

    instrDecoder u_decode (.instr(instr), .rsAddr(rsAddr), .rtAddr(rtAddr), .wrAddr(wrAddr),
        .aluOp(aluOp), .invA(invA), .invB(invB), .cin(cin), .useImm(useImm), .imm(imm),
        .wrEn(wrEn), .isHalt(isHalt));

    regFile u_regs (.clk(clk), .arstN(arstN), .rsAddr(rsAddr), .rtAddr(rtAddr), .wrEn(regWe),
        .wrAddr(wrAddr), .wrData(resultQ), .rsData(rsData), .rtData(rtData));

    assign bOperand = useImm ? imm : rtData;

    // Flags only feed the set operations inside the ALU
    alu u_alu (.a(rsData), .b(bOperand), .op(aluOp), .invA(invA), .invB(invB), .cin(cin),
        .result(aluResult), .zero(), .neg());

    always_ff @(posedge clk) begin
        if (execEn) begin
            resultQ <= aluResult;
        end
    end

    assign regWe       = commit && wrEn;   // NOP and HALT never write
    assign retireValid = regWe;
    assign retireReg   = wrAddr;
    assign retireData  = resultQ;

endmodule

/* verilog/instrMem.sv */
module instrMem (
    input  logic                          clk,
    input  logic                          progWe,
    input  logic [wiscPkg::pcWidth-1:0]   progAddr,
    input  logic [wiscPkg::dataWidth-1:0] progData,
    input  logic [wiscPkg::pcWidth-1:0]   pc,
    input  logic                          fetchEn,
    output logic [wiscPkg::dataWidth-1:0] instr
);
    import wiscPkg::*;

    logic [dataWidth-1:0] mem [1 << pcWidth];

    always_ff @(posedge clk) begin
        if (progWe) begin
            mem[progAddr] <= progData;   // Loaded while the core idles
        end
        if (fetchEn) begin
            instr <= mem[pc];   // Held until the next fetch
        end
    end

endmodule

/* verilog/coreControl.sv */
module coreControl (
    input  logic clk,
    input  logic arstN,
    input  logic start,
    input  logic isHalt,
    output logic pcClear,
    output logic pcAdvance,
    output logic fetchEn,
    output logic execEn,
    output logic commit,
    output logic halted
);
    import wiscPkg::*;

    ctrlStateE state;
    ctrlStateE stateNext;
    logic      canStart;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= StIdle;
        end else begin
            state <= stateNext;
        end
    end

    assign canStart = (state == StIdle) || (state == StHalted);

    always_comb begin
        stateNext = state;
        case (state)
            StIdle, StHalted: begin
                if (start) begin
                    stateNext = StFetch;
                end
            end
            StFetch:     stateNext = StDecode;
            StDecode:    stateNext = isHalt ? StHalted : StExecute;   // HALT seen here
            StExecute:   stateNext = StWriteback;
            StWriteback: stateNext = StFetch;
            default:     stateNext = StIdle;
        endcase
    end

    // Strobes decode straight from the state
    assign pcClear   = start && canStart;
    assign fetchEn   = (state == StFetch);
    assign execEn    = (state == StExecute);
    assign commit    = (state == StWriteback);
    assign pcAdvance = commit;
    assign halted    = (state == StHalted);

endmodule

/* verilog/pcCounter.sv */
module pcCounter (
    input  logic                        clk,
    input  logic                        arstN,
    input  logic                        pcClear,
    input  logic                        pcAdvance,
    output logic [wiscPkg::pcWidth-1:0] pc
);
    import wiscPkg::*;

    logic [pcWidth-1:0] pcQ;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pcQ <= '0;
        end else if (pcClear) begin
            pcQ <= '0;   // Program restarts at address 0
        end else if (pcAdvance) begin
            pcQ <= pcQ + 1'b1;   // Wraps at the top of memory
        end
    end

    assign pc = pcQ;

endmodule

/* verilog/regFile.sv */
module regFile (
    input  logic                             clk,
    input  logic                             arstN,
    input  logic [wiscPkg::regAddrWidth-1:0] rsAddr,
    input  logic [wiscPkg::regAddrWidth-1:0] rtAddr,
    input  logic                             wrEn,
    input  logic [wiscPkg::regAddrWidth-1:0] wrAddr,
    input  logic [wiscPkg::dataWidth-1:0]    wrData,
    output logic [wiscPkg::dataWidth-1:0]    rsData,
    output logic [wiscPkg::dataWidth-1:0]    rtData
);
    import wiscPkg::*;

    logic [dataWidth-1:0] regs [numRegs];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Read ports see the old value during the write cycle
    assign rsData = regs[rsAddr];
    assign rtData = regs[rtAddr];

endmodule

/* verilog/instrDecoder.sv */
module instrDecoder (
    input  logic [wiscPkg::dataWidth-1:0]    instr,
    output logic [wiscPkg::regAddrWidth-1:0] rsAddr,
    output logic [wiscPkg::regAddrWidth-1:0] rtAddr,
    output logic [wiscPkg::regAddrWidth-1:0] wrAddr,
    output wiscPkg::aluOpE                   aluOp,
    output logic                             invA,
    output logic                             invB,
    output logic                             cin,
    output logic                             useImm,
    output logic [wiscPkg::dataWidth-1:0]    imm,
    output logic                             wrEn,
    output logic                             isHalt
);
    import wiscPkg::*;

    opcodeE               opcode;
    logic                 isRType;
    logic [1:0]           opSel;
    logic [dataWidth-1:0] immSext5;
    logic [dataWidth-1:0] immZext5;
    logic [dataWidth-1:0] immSext8;
    logic [dataWidth-1:0] immZext8;

    assign opcode  = opcodeE'(instr[dataWidth-1 -: opWidth]);
    assign isRType = opcode inside {OpBtr, OpAluShift, OpAluArith, OpSeq, OpSlt, OpSle, OpSco};

    // Immediate forms reuse the low opcode bits in the same order as func
    assign opSel = isRType ? instr[1:0] : instr[12:11];

    assign rsAddr = instr[10:8];
    assign rtAddr = instr[7:5];

    assign immSext5 = {{(dataWidth-shortImmWidth){instr[shortImmWidth-1]}},
                       instr[shortImmWidth-1:0]};
    assign immZext5 = {{(dataWidth-shortImmWidth){1'b0}}, instr[shortImmWidth-1:0]};
    assign immSext8 = {{(dataWidth-byteWidth){instr[byteWidth-1]}}, instr[byteWidth-1:0]};
    assign immZext8 = {{(dataWidth-byteWidth){1'b0}}, instr[byteWidth-1:0]};

    always_comb begin
        aluOp  = AluPassB;
        invA   = 1'b0;
        invB   = 1'b0;
        cin    = 1'b0;
        useImm = !isRType;
        imm    = immZext5;
        wrAddr = isRType ? instr[4:2] : instr[7:5];
        wrEn   = 1'b1;
        isHalt = 1'b0;
        case (opcode)
            OpHalt: begin
                wrEn   = 1'b0;
                isHalt = 1'b1;
            end
            OpAddi, OpSubi, OpXori, OpAndni, OpAluArith: begin
                aluOp = opSel[1] ? (opSel[0] ? AluAndn : AluXor) : AluAdd;
                invA  = (opSel == 2'b01);   // SUB gives b - a
                cin   = (opSel == 2'b01);
                invB  = (opSel == 2'b11);
                imm   = opSel[1] ? immZext5 : immSext5;
            end
            OpRoli, OpSlli, OpRori, OpSrli, OpAluShift: begin
                case (opSel)
                    2'b00:   aluOp = AluRol;
                    2'b01:   aluOp = AluSll;
                    2'b10:   aluOp = AluRor;
                    default: aluOp = AluSrl;
                endcase
            end
            OpLbi: begin
                imm    = immSext8;
                wrAddr = instr[10:8];
            end
            OpSlbi: begin
                aluOp  = AluSlbi;
                imm    = immZext8;
                wrAddr = instr[10:8];
            end
            OpBtr: aluOp = AluBtr;
            OpSeq, OpSlt, OpSle: begin
                // rs - rt for the compares
                aluOp = (opcode == OpSeq) ? AluSeq : (opcode == OpSlt) ? AluSlt : AluSle;
                invB  = 1'b1;
                cin   = 1'b1;
            end
            OpSco: aluOp = AluSco;
            default: wrEn = 1'b0;   // NOP and unused opcodes
        endcase
    end

endmodule

/* verilog/alu.sv */
module alu (
    input  logic [wiscPkg::dataWidth-1:0] a,
    input  logic [wiscPkg::dataWidth-1:0] b,
    input  wiscPkg::aluOpE                op,
    input  logic                          invA,
    input  logic                          invB,
    input  logic                          cin,
    output logic [wiscPkg::dataWidth-1:0] result,
    output logic                          zero,
    output logic                          neg
);
    import wiscPkg::*;

    logic [dataWidth-1:0]   aMod;
    logic [dataWidth-1:0]   bMod;
    logic [dataWidth-1:0]   gen;
    logic [dataWidth-1:0]   prop;
    logic [dataWidth-1:0]   sum;
    logic [dataWidth:0]     carry;
    logic [claGroups-1:0]   grpGen;
    logic [claGroups-1:0]   grpProp;
    logic [claGroups:0]     grpCarry;
    logic [shAmtWidth-1:0]  shAmt;
    logic [2*dataWidth-1:0] rolWide;
    logic [2*dataWidth-1:0] rorWide;
    logic [dataWidth-1:0]   bitRev;

    assign aMod = invA ? ~a : a;
    assign bMod = invB ? ~b : b;

    assign gen  = aMod & bMod;
    assign prop = aMod ^ bMod;

    // Group generate/propagate for each 4-bit slice
    always_comb begin
        for (int g = 0; g < claGroups; g++) begin
            grpGen[g]  = 1'b0;
            grpProp[g] = 1'b1;
            for (int j = 0; j < claGroupWidth; j++) begin
                grpGen[g]  = gen[g*claGroupWidth+j] |
                             (prop[g*claGroupWidth+j] & grpGen[g]);
                grpProp[g] = grpProp[g] & prop[g*claGroupWidth+j];
            end
        end
    end

    // Lookahead across groups, then local carries inside each group
    always_comb begin
        grpCarry[0] = cin;
        for (int g = 0; g < claGroups; g++) begin
            grpCarry[g+1] = grpGen[g] | (grpProp[g] & grpCarry[g]);
        end
        for (int g = 0; g < claGroups; g++) begin
            carry[g*claGroupWidth] = grpCarry[g];
            for (int j = 0; j < claGroupWidth - 1; j++) begin
                carry[g*claGroupWidth+j+1] = gen[g*claGroupWidth+j] |
                    (prop[g*claGroupWidth+j] & carry[g*claGroupWidth+j]);
            end
        end
        carry[dataWidth] = grpCarry[claGroups];
    end

    assign sum = prop ^ carry[dataWidth-1:0];

    // Flags follow the adder, not the selected result
    assign zero = (sum == '0);
    assign neg  = sum[dataWidth-1] & ~zero;

    assign shAmt   = b[shAmtWidth-1:0];
    assign rolWide = {a, a} << shAmt;   // upper half holds the rotate
    assign rorWide = {a, a} >> shAmt;   // lower half holds the rotate

    always_comb begin
        for (int i = 0; i < dataWidth; i++) begin
            bitRev[i] = a[dataWidth-1-i];
        end
    end

    always_comb begin
        case (op)
            AluAdd:   result = sum;
            AluXor:   result = aMod ^ bMod;
            AluAndn:  result = aMod & bMod;   // invB supplies the NOT
            AluRol:   result = rolWide[2*dataWidth-1:dataWidth];
            AluSll:   result = a << shAmt;
            AluRor:   result = rorWide[dataWidth-1:0];
            AluSrl:   result = a >> shAmt;
            AluBtr:   result = bitRev;
            AluSeq:   result = {{(dataWidth-1){1'b0}}, zero};
            AluSlt:   result = {{(dataWidth-1){1'b0}}, neg};
            AluSle:   result = {{(dataWidth-1){1'b0}}, neg | zero};
            AluSco:   result = {{(dataWidth-1){1'b0}}, carry[dataWidth]};
            AluPassB: result = b;
            AluSlbi:  result = (a << byteWidth) | b;
            default:  result = '0;
        endcase
    end

endmodule

/* verilog/wiscPkg.sv */
package wiscPkg;

    localparam int dataWidth     = 16;
    localparam int regAddrWidth  = 3;
    localparam int pcWidth       = 8;
    localparam int opWidth       = 5;
    localparam int numRegs       = 1 << regAddrWidth;
    localparam int shAmtWidth    = 4;
    localparam int shortImmWidth = 5;
    localparam int byteWidth     = 8;
    localparam int claGroupWidth = 4;
    localparam int claGroups     = dataWidth / claGroupWidth;

    typedef enum logic [opWidth-1:0] {
        OpHalt     = 5'b00000,
        OpNop      = 5'b00001,
        OpAddi     = 5'b01000,
        OpSubi     = 5'b01001,
        OpXori     = 5'b01010,
        OpAndni    = 5'b01011,
        OpSlbi     = 5'b10010,
        OpRoli     = 5'b10100,
        OpSlli     = 5'b10101,
        OpRori     = 5'b10110,
        OpSrli     = 5'b10111,
        OpLbi      = 5'b11000,
        OpBtr      = 5'b11001,
        OpAluShift = 5'b11010,  // ROL/SLL/ROR/SRL by func
        OpAluArith = 5'b11011,  // ADD/SUB/XOR/ANDN by func
        OpSeq      = 5'b11100,
        OpSlt      = 5'b11101,
        OpSle      = 5'b11110,
        OpSco      = 5'b11111
    } opcodeE;

    typedef enum logic [3:0] {
        AluAdd, AluXor, AluAndn,
        AluRol, AluSll, AluRor, AluSrl,
        AluBtr, AluSeq, AluSlt, AluSle, AluSco,
        AluPassB, AluSlbi
    } aluOpE;

    typedef enum logic [2:0] {
        StIdle,
        StFetch,
        StDecode,
        StExecute,
        StWriteback,
        StHalted
    } ctrlStateE;

endpackage
